// ==== top.f ====
design/board_pkg.sv
design/reset_stretcher.sv
design/uart_rx.sv
design/command_decoder.sv
design/vga_timing.sv
design/bar_pattern.sv
design/top.sv
testbench/top_assertions.sv
testbench/top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the top_tb simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module top_tb \
  -f top.f --Mdir obj_dir -o top_tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/top_tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^STATUS: PASS$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== testbench/top_stimulus.txt ====
# columns: uart byte, expected leds, expected tint (all hex)
# the last line is sent only after the button reset
05 05 00
4a a5 00
9b a5 1b
0f af 1b
7c cf 1b
e5 cf 25
3f cf 25
2a ca 25
bf ca 3f
51 10 00

// ==== testbench/top_tb.sv ====
`timescale 1ns/1ps

module top_tb;
  import board_pkg::*;

  logic                   clk_25mhz = 1'b0;
  logic                   rst_n;
  logic [num_btns-1:0]    btns;
  logic                   ftdi_txd;
  logic [num_leds-1:0]    leds;
  logic                   vga_hs;
  logic                   vga_vs;
  logic [color_depth-1:0] vga_r;
  logic [color_depth-1:0] vga_g;
  logic [color_depth-1:0] vga_b;

  logic [7:0]  stim_byte[$];
  logic [7:0]  stim_leds[$];
  logic [7:0]  stim_tint[$];
  int          num_lines = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          test_errors = 0;

  top dut_i (
    .clk_25mhz (clk_25mhz),
    .rst_n     (rst_n),
    .btns      (btns),
    .ftdi_txd  (ftdi_txd),
    .leds      (leds),
    .vga_hs    (vga_hs),
    .vga_vs    (vga_vs),
    .vga_r     (vga_r),
    .vga_g     (vga_g),
    .vga_b     (vga_b)
  );

  always #20 clk_25mhz = ~clk_25mhz;

  task automatic check_val(input string name, input int expected, input int actual);
    assert (expected == actual) else begin
      $display("mismatch %s: expected %0h, actual %0h", name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: failed with %0d errors", name, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  task automatic load_stimulus();
    int         fd;
    string      line;
    logic [7:0] b;
    logic [7:0] l;
    logic [7:0] t;
    fd = $fopen("testbench/top_stimulus.txt", "r");
    if (fd == 0) begin
      $display("cannot open testbench/top_stimulus.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line[0] != "#" && $sscanf(line, "%h %h %h", b, l, t) == 3) begin
          stim_byte.push_back(b);
          stim_leds.push_back(l);
          stim_tint.push_back(t);
        end
      end
      $fclose(fd);
      num_lines = stim_byte.size();
    end
  endtask

  // 8N1, lsb first
  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      ftdi_txd <= frame[i];
      repeat (uart_clks_per_bit) @(posedge clk_25mhz);
    end
  endtask

  task automatic run_command(input int idx, input string name);
    int unsigned gap;
    gap = 1 + ($urandom % 4);
    @(posedge clk_25mhz);
    send_byte(stim_byte[idx]);
    repeat ((1 + gap) * uart_clks_per_bit) @(posedge clk_25mhz);
    @(negedge clk_25mhz);
    check_val({name, "_leds"}, int'(stim_leds[idx]), int'(leds));
    check_val({name, "_tint"}, int'(stim_tint[idx]), int'(dut_i.tint));
    end_test(name);
  endtask

  // counts sampled cycles until the chosen sync reaches level
  task automatic count_until(input bit use_vs, input logic level, output int n);
    n = 0;
    do begin
      @(negedge clk_25mhz);
      n++;
    end while ((use_vs ? vga_vs : vga_hs) !== level);
  endtask

  task automatic test_reset_values();
    repeat (5) @(posedge clk_25mhz);
    rst_n <= 1'b1;
    repeat (reset_hold_cycles + 4) @(posedge clk_25mhz);
    @(negedge clk_25mhz);
    check_val("reset_leds", 0, int'(leds));
    check_val("reset_rgb", 0, int'({vga_r, vga_g, vga_b}));
    check_val("reset_syncs", 3, int'({vga_hs, vga_vs}));
    end_test("reset_values");
  endtask

  task automatic test_sync();
    int n;
    int low_len;
    int high_len;
    count_until(1'b0, 1'b1, n);
    count_until(1'b0, 1'b0, n);
    for (int line_no = 0; line_no < 3; line_no++) begin
      count_until(1'b0, 1'b1, low_len);
      count_until(1'b0, 1'b0, high_len);
      check_val("hsync_low", h_sync, low_len);
      check_val("hsync_period", h_total, low_len + high_len);
    end
    end_test("hsync");
    count_until(1'b1, 1'b1, n);
    count_until(1'b1, 1'b0, n);
    count_until(1'b1, 1'b1, low_len);
    check_val("vsync_low", v_sync * h_total, low_len);
    end_test("vsync");
  endtask

  task automatic test_bars(input int bar_tint);
    int n;
    int k;
    int elapsed;
    // wait for an hs rise whose next line is visible
    do begin
      count_until(1'b0, 1'b0, n);
      count_until(1'b0, 1'b1, n);
    end while (dut_i.v_count >= 10'(v_active - 1));
    elapsed = 0;
    for (int i = 0; i < 9; i++) begin
      k = (i < 8) ? bar_width / 2 + bar_width * i : h_active + 10;
      // hs rises at the output for h_count 752, so pixel k follows 48 + k cycles later
      repeat (h_total - hs_end + k - elapsed) @(negedge clk_25mhz);
      elapsed = h_total - hs_end + k;
      check_val($sformatf("bar_%0d_red", i), (i < 8 && i[0]) ? bar_tint : 0, int'(vga_r));
      check_val($sformatf("bar_%0d_green", i), (i < 8 && i[1]) ? bar_tint : 0, int'(vga_g));
      check_val($sformatf("bar_%0d_blue", i), (i < 8 && i[2]) ? bar_tint : 0, int'(vga_b));
    end
    end_test("bar_colours");
  endtask

  task automatic test_button_reset();
    @(posedge clk_25mhz);
    btns[0] <= 1'b0;
    repeat (3) @(posedge clk_25mhz);
    btns[0] <= 1'b1;
    repeat (reset_hold_cycles + 4) @(posedge clk_25mhz);
    @(negedge clk_25mhz);
    check_val("button_leds", 0, int'(leds));
    check_val("button_tint", 0, int'(dut_i.tint));
    end_test("button_reset");
  endtask

  initial begin
    rst_n    <= 1'b0;
    btns     <= 7'b000_0001;
    ftdi_txd <= 1'b1;
    void'($urandom(28));
    load_stimulus();
    if (num_lines >= 2) begin
      test_reset_values();
      for (int i = 0; i < num_lines - 1; i++) begin
        run_command(i, $sformatf("cmd_%0d", i));
      end
      test_sync();
      test_bars(int'(stim_tint[num_lines - 2]));
      test_button_reset();
      run_command(num_lines - 1, "cmd_after_reset");
    end else begin
      $display("stimulus file is missing or holds fewer than two lines");
      tests_failed++;
    end
    $display("tests run %0d, failed %0d", tests_run, tests_failed);
    if (tests_failed == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // 15 bit times per byte plus two video frames
  initial begin
    longint limit;
    wait (num_lines > 0);
    limit = longint'(num_lines) * 15 * uart_clks_per_bit + 2 * h_total * v_total;
    repeat (limit) @(posedge clk_25mhz);
    $display("timeout: tests did not finish within %0d clock cycles", limit);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== testbench/top_assertions.sv ====
`timescale 1ns/1ps

module top_assertions (
  input logic clk_25mhz,
  input logic rst_n,
  input logic byte_req,
  input logic byte_ack,
  input logic vga_hs
);
  import board_pkg::*;

  logic [9:0] hs_low_cnt;

  // length of the current hs low pulse
  always_ff @(posedge clk_25mhz or negedge rst_n) begin
    if (!rst_n) begin
      hs_low_cnt <= '0;
    end else if (!vga_hs) begin
      hs_low_cnt <= hs_low_cnt + 10'd1;
    end else begin
      hs_low_cnt <= '0;
    end
  end

  ack_needs_req: assert property (@(posedge clk_25mhz) disable iff (!rst_n)
    $rose(byte_ack) |-> $past(byte_req))
    else $error("byte_ack rose while byte_req was low");

  req_held: assert property (@(posedge clk_25mhz) disable iff (!rst_n)
    byte_req && !byte_ack |=> byte_req)
    else $error("byte_req dropped before byte_ack was seen");

  hs_width: assert property (@(posedge clk_25mhz) disable iff (!rst_n)
    $rose(vga_hs) |-> hs_low_cnt == 10'(h_sync))
    else $error("vga_hs low pulse differs from h_sync cycles");

endmodule

bind top top_assertions top_assertions_i (
  .clk_25mhz (clk_25mhz),
  .rst_n     (sys_rst_n),
  .byte_req  (byte_req),
  .byte_ack  (byte_ack),
  .vga_hs    (vga_hs)
);

// ==== design/top.sv ====
`timescale 1ns/1ps

module top (
  input  logic                              clk_25mhz,
  input  logic                              rst_n,
  input  logic [board_pkg::num_btns-1:0]    btns,
  input  logic                              ftdi_txd,
  output logic [board_pkg::num_leds-1:0]    leds,
  output logic                              vga_hs,
  output logic                              vga_vs,
  output logic [board_pkg::color_depth-1:0] vga_r,
  output logic [board_pkg::color_depth-1:0] vga_g,
  output logic [board_pkg::color_depth-1:0] vga_b
);
  import board_pkg::*;

  logic                   sys_rst_n;
  logic                   byte_req;
  logic                   byte_ack;
  logic [7:0]             rx_byte;
  logic [color_depth-1:0] tint;
  logic [9:0]             h_count;
  logic [9:0]             v_count;
  logic                   active;
  logic                   hs_raw;
  logic                   vs_raw;

  // btns[0] doubles as the board ready line
  reset_stretcher reset_stretcher_i (
    .clk_25mhz (clk_25mhz),
    .rst_n     (rst_n),
    .ready     (btns[0]),
    .sys_rst_n (sys_rst_n)
  );

  uart_rx uart_rx_i (
    .clk_25mhz (clk_25mhz),
    .rst_n     (sys_rst_n),
    .rx        (ftdi_txd),
    .byte_req  (byte_req),
    .rx_byte   (rx_byte),
    .byte_ack  (byte_ack)
  );

  command_decoder command_decoder_i (
    .clk_25mhz (clk_25mhz),
    .rst_n     (sys_rst_n),
    .byte_req  (byte_req),
    .rx_byte   (rx_byte),
    .byte_ack  (byte_ack),
    .leds      (leds),
    .tint      (tint)
  );

  vga_timing vga_timing_i (
    .clk_25mhz (clk_25mhz),
    .rst_n     (sys_rst_n),
    .h_count   (h_count),
    .v_count   (v_count),
    .active    (active),
    .hs_raw    (hs_raw),
    .vs_raw    (vs_raw)
  );

  bar_pattern bar_pattern_i (
    .clk_25mhz (clk_25mhz),
    .rst_n     (sys_rst_n),
    .h_count   (h_count),
    .active    (active),
    .hs_raw    (hs_raw),
    .vs_raw    (vs_raw),
    .tint      (tint),
    .vga_r     (vga_r),
    .vga_g     (vga_g),
    .vga_b     (vga_b),
    .vga_hs    (vga_hs),
    .vga_vs    (vga_vs)
  );

endmodule

// ==== design/bar_pattern.sv ====
`timescale 1ns/1ps

module bar_pattern (
  input  logic                              clk_25mhz,
  input  logic                              rst_n,
  input  logic [9:0]                        h_count,
  input  logic                              active,
  input  logic                              hs_raw,
  input  logic                              vs_raw,
  input  logic [board_pkg::color_depth-1:0] tint,
  output logic [board_pkg::color_depth-1:0] vga_r,
  output logic [board_pkg::color_depth-1:0] vga_g,
  output logic [board_pkg::color_depth-1:0] vga_b,
  output logic                              vga_hs,
  output logic                              vga_vs
);
  import board_pkg::*;

  logic [2:0]             bar_idx;
  logic [color_depth-1:0] r_next;
  logic [color_depth-1:0] g_next;
  logic [color_depth-1:0] b_next;

  // only meaningful inside the active region
  assign bar_idx = 3'(h_count / bar_width);

  assign r_next = (active && bar_idx[0]) ? tint : '0;
  assign g_next = (active && bar_idx[1]) ? tint : '0;
  assign b_next = (active && bar_idx[2]) ? tint : '0;

  // syncs share the colour register stage
  always_ff @(posedge clk_25mhz or negedge rst_n) begin
    if (!rst_n) begin
      vga_r  <= '0;
      vga_g  <= '0;
      vga_b  <= '0;
      vga_hs <= 1'b1;
      vga_vs <= 1'b1;
    end else begin
      vga_r  <= r_next;
      vga_g  <= g_next;
      vga_b  <= b_next;
      vga_hs <= hs_raw;
      vga_vs <= vs_raw;
    end
  end

endmodule

// ==== design/vga_timing.sv ====
`timescale 1ns/1ps

module vga_timing (
  input  logic       clk_25mhz,
  input  logic       rst_n,
  output logic [9:0] h_count,
  output logic [9:0] v_count,
  output logic       active,
  output logic       hs_raw,
  output logic       vs_raw
);
  import board_pkg::*;

  logic h_wrap;
  logic v_wrap;

  assign h_wrap = (h_count == 10'(h_total - 1));
  assign v_wrap = (v_count == 10'(v_total - 1));

  always_ff @(posedge clk_25mhz or negedge rst_n) begin
    if (!rst_n) begin
      h_count <= '0;
    end else if (h_wrap) begin
      h_count <= '0;
    end else begin
      h_count <= h_count + 10'd1;
    end
  end

  // one line per horizontal wrap
  always_ff @(posedge clk_25mhz or negedge rst_n) begin
    if (!rst_n) begin
      v_count <= '0;
    end else if (h_wrap) begin
      if (v_wrap) begin
        v_count <= '0;
      end else begin
        v_count <= v_count + 10'd1;
      end
    end
  end

  // both syncs are active low
  assign hs_raw = !((h_count >= 10'(hs_start)) && (h_count < 10'(hs_end)));
  assign vs_raw = !((v_count >= 10'(vs_start)) && (v_count < 10'(vs_end)));

  assign active = (h_count < 10'(h_active)) && (v_count < 10'(v_active));

endmodule

// ==== design/command_decoder.sv ====
`timescale 1ns/1ps

module command_decoder (
  input  logic                         clk_25mhz,
  input  logic                         rst_n,
  input  logic                         byte_req,
  input  logic [7:0]                   rx_byte,
  output logic                         byte_ack,
  output logic [board_pkg::num_leds-1:0]    leds,
  output logic [board_pkg::color_depth-1:0] tint
);
  import board_pkg::*;

  logic [1:0] code;

  assign code = rx_byte[7:6];

  // ack side of the four-phase handshake
  always_ff @(posedge clk_25mhz or negedge rst_n) begin
    if (!rst_n) begin
      byte_ack <= 1'b0;
      leds     <= '0;
      tint     <= '0;
    end else if (byte_req && !byte_ack) begin
      byte_ack <= 1'b1;
      if (code[1] == cmd_tint[1]) begin
        tint <= rx_byte[color_depth-1:0];
      end else if (code == cmd_leds_low) begin
        leds[3:0] <= rx_byte[3:0];
      end else if (code == cmd_leds_high) begin
        leds[7:4] <= rx_byte[3:0];
      end
    end else if (byte_ack && !byte_req) begin
      // sender has seen the ack
      byte_ack <= 1'b0;
    end
  end

endmodule

// ==== design/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx (
  input  logic       clk_25mhz,
  input  logic       rst_n,
  input  logic       rx,
  output logic       byte_req,
  output logic [7:0] rx_byte,
  input  logic       byte_ack
);
  import board_pkg::*;

  typedef enum logic [1:0] {idle, start, data, stop} rx_state_t;
  typedef enum logic [1:0] {hs_idle, offer, wait_ack_low} hs_state_t;

  logic                      rx_meta;
  logic                      rx_s;
  rx_state_t                 state;
  hs_state_t                 hs_state;
  logic [uart_cnt_width-1:0] tick_cnt;
  logic [2:0]                bit_idx;
  logic [7:0]                shift;
  logic                      frame_done;
  logic                      bit_tick;

  assign bit_tick = (tick_cnt == uart_cnt_width'(uart_clks_per_bit - 1));

  // line idles high
  always_ff @(posedge clk_25mhz or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_s    <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_s    <= rx_meta;
    end
  end

  always_ff @(posedge clk_25mhz or negedge rst_n) begin
    if (!rst_n) begin
      state      <= idle;
      tick_cnt   <= '0;
      bit_idx    <= '0;
      frame_done <= 1'b0;
    end else begin
      frame_done <= 1'b0;
      tick_cnt   <= tick_cnt + 1'b1;
      case (state)
        idle: begin
          tick_cnt <= '0;
          if (!rx_s) begin
            state <= start;
          end
        end
        start: begin
          // still low at mid-bit, so a real start bit
          if (tick_cnt == uart_cnt_width'(uart_half_bit - 1)) begin
            tick_cnt <= '0;
            bit_idx  <= '0;
            state    <= rx_s ? idle : data;
          end
        end
        data: begin
          if (bit_tick) begin
            tick_cnt <= '0;
            bit_idx  <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= stop;
            end
          end
        end
        stop: begin
          // low stop bit drops the frame
          if (bit_tick) begin
            frame_done <= rx_s;
            state      <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // lsb first
  always_ff @(posedge clk_25mhz) begin
    if (state == data && bit_tick) begin
      shift <= {rx_s, shift[7:1]};
    end
  end

  // frames finishing while a handshake is open are lost
  always_ff @(posedge clk_25mhz or negedge rst_n) begin
    if (!rst_n) begin
      hs_state <= hs_idle;
      byte_req <= 1'b0;
    end else begin
      case (hs_state)
        hs_idle: begin
          if (frame_done) begin
            byte_req <= 1'b1;
            hs_state <= offer;
          end
        end
        offer: begin
          if (byte_ack) begin
            byte_req <= 1'b0;
            hs_state <= wait_ack_low;
          end
        end
        wait_ack_low: begin
          if (!byte_ack) begin
            hs_state <= hs_idle;
          end
        end
        default: hs_state <= hs_idle;
      endcase
    end
  end

  always_ff @(posedge clk_25mhz) begin
    if (hs_state == hs_idle && frame_done) begin
      rx_byte <= shift;
    end
  end

endmodule

// ==== design/reset_stretcher.sv ====
`timescale 1ns/1ps

module reset_stretcher (
  input  logic clk_25mhz,
  input  logic rst_n,
  input  logic ready,
  output logic sys_rst_n
);
  import board_pkg::*;

  logic                       src_n;
  logic [reset_cnt_width-1:0] hold_cnt;

  // either source forces reset at once
  assign src_n = rst_n & ready;

  // release only after the count drains
  always_ff @(posedge clk_25mhz or negedge src_n) begin
    if (!src_n) begin
      hold_cnt  <= reset_cnt_width'(reset_hold_cycles - 1);
      sys_rst_n <= 1'b0;
    end else if (hold_cnt != '0) begin
      hold_cnt <= hold_cnt - 1'b1;
    end else begin
      sys_rst_n <= 1'b1;
    end
  end

endmodule

// ==== design/board_pkg.sv ====
package board_pkg;

  // board resources
  localparam int color_depth = 6;
  localparam int num_leds    = 8;
  localparam int num_btns    = 7;

  // reset stretch length and its counter width
  localparam int reset_hold_cycles = 32;
  localparam int reset_cnt_width   = $clog2(reset_hold_cycles);

  // 115200 baud from 25 MHz
  localparam int uart_clks_per_bit = 217;
  localparam int uart_half_bit     = uart_clks_per_bit / 2;
  localparam int uart_cnt_width    = $clog2(uart_clks_per_bit);

  // 640x480 at 60 Hz
  localparam int h_active = 640;
  localparam int h_front  = 16;
  localparam int h_sync   = 96;
  localparam int h_back   = 48;
  localparam int h_total  = h_active + h_front + h_sync + h_back;
  localparam int hs_start = h_active + h_front;
  localparam int hs_end   = hs_start + h_sync;

  localparam int v_active = 480;
  localparam int v_front  = 10;
  localparam int v_sync   = 2;
  localparam int v_back   = 33;
  localparam int v_total  = v_active + v_front + v_sync + v_back;
  localparam int vs_start = v_active + v_front;
  localparam int vs_end   = vs_start + v_sync;

  localparam int bar_width = 80;

  // command code sits in byte bits 7:6
  localparam logic [1:0] cmd_leds_low  = 2'b00;
  localparam logic [1:0] cmd_leds_high = 2'b01;
  // only bit 1 is decoded for tint
  localparam logic [1:0] cmd_tint      = 2'b10;

endpackage
